// File: vlog.f
design/sprite_pkg.sv
design/table_loader.sv
design/column_renderer.sv
design/line_buffer.sv
design/colour_output.sv
design/sprite_line_top.sv
testbench/tb_clock.sv
testbench/sprite_line_assertions.sv
testbench/sprite_line_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sprite line testbench with Verilator
rm -f sim.log && \
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module sprite_line_tb -f vlog.f -o sprite_line_sim > build.log 2>&1 && \
./obj_dir/sprite_line_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: testbench/sprite_line_tb.sv
`timescale 1ns/1ps

module sprite_line_tb;
    import sprite_pkg::*;

    localparam int full_dl_bytes = 2 * (2**spr_ram_addr_bits) + 2 * (2**bitmap_addr_bits)
                                 + 2**(tile_bits + 1) + 2 * (2**clut_addr_bits) + 4 * 256;
    localparam int num_tests       = 5;
    localparam int num_lines       = 11;
    localparam int line_cycles     = 4000;
    localparam int watchdog_cycles = num_tests * full_dl_bytes + num_lines * line_cycles + 5000;

    logic       clk_sys;
    logic       reset;
    dl_byte_t   dl;
    logic       line_start;
    logic [7:0] line;
    logic       line_busy;
    logic       line_done;
    logic       pixel_req;
    logic [7:0] pixel_x;
    rgb_t       rgb;
    logic       rgb_valid;

    integer     seed;
    int         err_count;
    int         test_err_mark;
    int         tests_run;
    int         done_count;
    int         done_mark;
    int         total_errors;
    logic [7:0] y;
    logic [7:0] common_x;
    rgb_t       background;

    // mirrors of the five tables
    logic [15:0] m_spr  [2**spr_ram_addr_bits];
    logic [15:0] m_bmp  [2**bitmap_addr_bits];
    logic [7:0]  m_tc   [2**(tile_bits + 1)];
    logic [7:0]  m_clut [2**clut_addr_bits];
    logic [31:0] m_pal  [256];

    pixel_t model_line [line_width];
    rgb_t   exp_rgb    [line_width];

    tb_clock u_clock (
        .clk_sys (clk_sys)
    );

    sprite_line_top uut (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .dl         (dl),
        .line_start (line_start),
        .line       (line),
        .line_busy  (line_busy),
        .line_done  (line_done),
        .pixel_req  (pixel_req),
        .pixel_x    (pixel_x),
        .rgb        (rgb),
        .rgb_valid  (rgb_valid)
    );

    always @(posedge clk_sys) begin
        if (reset) begin
            done_count <= 0;
        end else if (line_done) begin
            done_count <= done_count + 1;
        end
    end

    // ==============================
    // helpers
    // ==============================
    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [7:0] rand_line();
        logic [31:0] r;
        r = rand32();
        return r[7:0];
    endfunction

    // 4 bit guns from palette bits 27:24, 19:16, 11:8
    function automatic rgb_t expand_rgb(input logic [31:0] pal);
        rgb_t c;
        c.r = {pal[27:24], pal[27:24]};
        c.g = {pal[19:16], pal[19:16]};
        c.b = {pal[11:8], pal[11:8]};
        return c;
    endfunction

    task automatic compare_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_done(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s line_done: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_busy(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s line_busy: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic randomize_tables();
        int i;
        logic [31:0] r;
        for (i = 0; i < 2**spr_ram_addr_bits; i++) begin
            r = rand32();
            m_spr[i] = r[15:0];
        end
        for (i = 0; i < 2**bitmap_addr_bits; i++) begin
            r = rand32();
            m_bmp[i] = r[15:0];
        end
        for (i = 0; i < 2**(tile_bits + 1); i++) begin
            r = rand32();
            m_tc[i] = r[7:0];
        end
        for (i = 0; i < 2**clut_addr_bits; i++) begin
            r = rand32();
            m_clut[i] = r[7:0];
        end
        for (i = 0; i < 256; i++) begin
            m_pal[i] = rand32();
        end
    endtask

    // ==============================
    // download port
    // ==============================
    task automatic send_byte(input logic [19:0] addr, input logic [7:0] data);
        @(negedge clk_sys);
        dl.wr   = 1'b1;
        dl.addr = addr;
        dl.data = data;
    endtask

    task automatic end_download();
        @(negedge clk_sys);
        dl.wr = 1'b0;
        repeat (2) @(negedge clk_sys);
    endtask

    task automatic load_spr_ram();
        int i;
        logic [19:0] a;
        for (i = 0; i < 2**spr_ram_addr_bits; i++) begin
            a = dl_spr_base + 20'(2 * i);
            send_byte(a, m_spr[i][15:8]);
            send_byte(a + 20'd1, m_spr[i][7:0]);
        end
        end_download();
    endtask

    task automatic load_bitmap();
        int i;
        logic [19:0] a;
        for (i = 0; i < 2**bitmap_addr_bits; i++) begin
            a = dl_bitmap_base + 20'(2 * i);
            send_byte(a, m_bmp[i][15:8]);
            send_byte(a + 20'd1, m_bmp[i][7:0]);
        end
        end_download();
    endtask

    task automatic load_colour_tables();
        int i;
        logic [19:0] a;
        logic [31:0] junk;
        for (i = 0; i < 2**(tile_bits + 1); i++) begin
            send_byte(dl_tile_colour_base + 20'(i), m_tc[i]);
        end
        // clut upper nibbles carry junk that must be dropped
        for (i = 0; i < 2**clut_addr_bits; i++) begin
            a = dl_clut_base + 20'(2 * i);
            junk = rand32();
            send_byte(a, {junk[3:0], m_clut[i][3:0]});
            send_byte(a + 20'd1, {junk[7:4], m_clut[i][7:4]});
        end
        for (i = 0; i < 256; i++) begin
            a = dl_palette_base + 20'(4 * i);
            send_byte(a, m_pal[i][31:24]);
            send_byte(a + 20'd1, m_pal[i][23:16]);
            send_byte(a + 20'd2, m_pal[i][15:8]);
            send_byte(a + 20'd3, m_pal[i][7:0]);
        end
        end_download();
    endtask

    task automatic load_all_tables();
        load_spr_ram();
        load_bitmap();
        load_colour_tables();
    endtask

    // ==============================
    // reference model
    // ==============================
    task automatic render_model(input logic [7:0] line_no);
        int p;
        int c;
        int h;
        int o;
        logic [1:0]  grp;
        logic [15:0] ce;
        logic [15:0] te;
        logic [15:0] d;
        logic [7:0]  col_y;
        logic [7:0]  row;
        logic [2:0]  r;
        logic [9:0]  tile;
        logic [7:0]  colour;
        logic [3:0]  pen;
        logic [7:0]  x;
        for (p = 0; p < line_width; p++) begin
            model_line[p] = '0;
        end
        // draw order 2, 3, 1, later writers win
        for (p = 0; p < num_groups; p++) begin
            grp = (p == 0) ? 2'd2 : ((p == 1) ? 2'd3 : 2'd1);
            for (c = 0; c < num_columns; c++) begin
                ce     = m_spr[{2'b00, 5'(c), 3'b000, grp}];
                col_y  = 8'h01 - ce[15:8];
                row    = line_no - col_y;
                te     = m_spr[{grp, 5'(c), row[7:3]}];
                tile   = te[9:0];
                colour = m_tc[{tile, te[15]}];
                r      = te[14] ? ~row[2:0] : row[2:0];
                for (h = 0; h < 2; h++) begin
                    d = m_bmp[{tile, 1'(h), r}];
                    for (o = 0; o < 4; o++) begin
                        pen = {d[4 + o], d[o], d[12 + o], d[8 + o]};
                        if (pen != 4'd0) begin
                            x = ce[7:0] + 8'(4 * h + o);
                            model_line[x].colour = colour;
                            model_line[x].pen    = pen;
                        end
                    end
                end
            end
        end
    endtask

    task automatic build_expected(input logic [7:0] line_no);
        int p;
        render_model(line_no);
        for (p = 0; p < line_width; p++) begin
            exp_rgb[p] = expand_rgb(m_pal[m_clut[{model_line[p].colour[5:0],
                                                  model_line[p].pen}]]);
        end
    endtask

    // ==============================
    // line control and readout
    // ==============================
    task automatic start_line(input string name, input logic [7:0] line_no);
        @(negedge clk_sys);
        compare_busy(name, 1'b0, line_busy);
        done_mark  = done_count;
        line_start = 1'b1;
        line       = line_no;
        @(negedge clk_sys);
        line_start = 1'b0;
        // busy from the cycle after the strobe
        compare_busy(name, 1'b1, line_busy);
    endtask

    task automatic wait_line_done(input string name);
        int n;
        n = 0;
        while (done_count == done_mark && n < line_cycles) begin
            @(negedge clk_sys);
            n++;
        end
        compare_done(name, 1'b1, done_count != done_mark);
        compare_busy(name, 1'b0, line_busy);
    endtask

    // back to back requests, response due pix_latency cycles later
    task automatic read_line(input string name);
        int k;
        logic vld;
        rgb_t got;
        for (k = 0; k < line_width + pix_latency + 4; k++) begin
            @(negedge clk_sys);
            vld = rgb_valid;
            got = rgb;
            if (k >= pix_latency && k < line_width + pix_latency) begin
                if (!vld) begin
                    $display("%s: no rgb_valid for pixel %0d at the expected cycle",
                             name, k - pix_latency);
                    err_count++;
                end else begin
                    compare_rgb($sformatf("%s pixel %0d", name, k - pix_latency),
                                exp_rgb[k - pix_latency], got);
                end
            end else if (vld) begin
                $display("%s: rgb_valid high with no matching request", name);
                err_count++;
            end
            if (k < line_width) begin
                pixel_req = 1'b1;
                pixel_x   = 8'(k);
            end else begin
                pixel_req = 1'b0;
            end
        end
    endtask

    // render line_no, then read it while the next line renders
    task automatic check_line(input string name, input logic [7:0] line_no);
        start_line(name, line_no);
        wait_line_done(name);
        start_line(name, line_no + 8'd1);
        read_line(name);
        wait_line_done(name);
    endtask

    task automatic finish_test(input string name);
        int n;
        n = err_count - test_err_mark;
        tests_run++;
        if (n == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n);
        end
        test_err_mark = err_count;
    endtask

    // ==============================
    // watchdog
    // ==============================
    initial begin
        repeat (watchdog_cycles) @(posedge clk_sys);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int i;
        int c;
        int g;
        logic [31:0] r;
        dl            = '0;
        line_start    = 1'b0;
        line          = 8'd0;
        pixel_req     = 1'b0;
        pixel_x       = 8'd0;
        reset         = 1'b1;
        seed          = 32'h37337dde;
        err_count     = 0;
        test_err_mark = 0;
        tests_run     = 0;
        done_mark     = 0;
        repeat (10) @(negedge clk_sys);
        reset = 1'b0;

        // every pen 0, only the cleared background shows
        randomize_tables();
        for (i = 0; i < 2**bitmap_addr_bits; i++) begin
            m_bmp[i] = 16'h0000;
        end
        load_all_tables();
        background = expand_rgb(m_pal[m_clut[0]]);
        for (i = 0; i < line_width; i++) begin
            exp_rgb[i] = background;
        end
        check_line("transparent_line", rand_line());
        finish_test("transparent_line");

        randomize_tables();
        load_all_tables();
        y = rand_line();
        build_expected(y);
        check_line("random_line", y);
        finish_test("random_line");

        // flip bit on every tile entry, groups 1 to 3
        for (i = 2**(spr_ram_addr_bits - 2); i < 2**spr_ram_addr_bits; i++) begin
            m_spr[i][14] = 1'b1;
        end
        load_spr_ram();
        y = rand_line();
        build_expected(y);
        check_line("flip_y", y);
        finish_test("flip_y");

        // all columns at one x, sparse bitmap so earlier writers can show through
        common_x = rand_line();
        for (g = 1; g <= num_groups; g++) begin
            for (c = 0; c < num_columns; c++) begin
                m_spr[{2'b00, 5'(c), 3'b000, 2'(g)}][7:0] = common_x;
            end
        end
        for (i = 0; i < 2**bitmap_addr_bits; i++) begin
            r = rand32();
            m_bmp[i] = (r[20:16] == 5'd0) ? r[15:0] : 16'h0000;
        end
        load_spr_ram();
        load_bitmap();
        y = rand_line();
        build_expected(y);
        check_line("overlap_priority", y);
        finish_test("overlap_priority");

        // three lines chained, each read while the next renders
        randomize_tables();
        load_all_tables();
        y = rand_line();
        build_expected(y);
        check_line("streaming", y);
        build_expected(y + 8'd1);
        start_line("streaming", y + 8'd2);
        read_line("streaming");
        wait_line_done("streaming");
        finish_test("streaming");

        repeat (8) @(negedge clk_sys);
        total_errors = err_count + uut.u_assertions.fail_count;
        $display("tests run %0d, errors %0d", tests_run, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: testbench/sprite_line_assertions.sv
`timescale 1ns/1ps

module sprite_line_assertions (
    input logic clk_sys,
    input logic reset,
    input logic pixel_req,
    input logic rgb_valid,
    input logic line_busy,
    input logic line_done,
    input logic buf_wr_en
);
    import sprite_pkg::*;

    int fail_count = 0;

    // fixed length read pipeline, no stalls
    rgb_latency: assert property (@(posedge clk_sys) disable iff (reset)
        rgb_valid == $past(pixel_req, pix_latency))
        else begin
            $error("rgb_valid does not follow pixel_req by %0d cycles", pix_latency);
            fail_count++;
        end

    // done marks the last busy cycle of a line
    done_in_busy: assert property (@(posedge clk_sys) disable iff (reset)
        line_done |=> !line_busy && $past(line_busy))
        else begin
            $error("line_done was not the last cycle of line_busy");
            fail_count++;
        end

    // clear and draw writes belong to a running line
    write_in_busy: assert property (@(posedge clk_sys) disable iff (reset)
        buf_wr_en |-> line_busy)
        else begin
            $error("line buffer written while line_busy was low");
            fail_count++;
        end

endmodule

bind sprite_line_top sprite_line_assertions u_assertions (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .pixel_req (pixel_req),
    .rgb_valid (rgb_valid),
    .line_busy (line_busy),
    .line_done (line_done),
    .buf_wr_en (buf_wr.en)
);

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_sys
);

    // 4 ns period
    localparam int half_period = 2;

    initial begin
        clk_sys = 1'b0;
        forever #half_period clk_sys = ~clk_sys;
    end

endmodule

// File: design/sprite_line_top.sv
`timescale 1ns/1ps

module sprite_line_top (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  sprite_pkg::dl_byte_t dl,
    input  logic                 line_start,
    input  logic [7:0]           line,
    output logic                 line_busy,
    output logic                 line_done,
    input  logic                 pixel_req,
    input  logic [7:0]           pixel_x,
    output sprite_pkg::rgb_t     rgb,
    output logic                 rgb_valid
);
    import sprite_pkg::*;

    table_write_t tbl_wr;
    line_write_t  buf_wr;
    pixel_t       rd_pixel;
    logic         rd_valid;

    table_loader u_loader (
        .clk_sys (clk_sys),
        .reset   (reset),
        .dl      (dl),
        .tbl_wr  (tbl_wr)
    );

    column_renderer u_renderer (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .tbl_wr     (tbl_wr),
        .line_start (line_start),
        .line       (line),
        .line_busy  (line_busy),
        .line_done  (line_done),
        .buf_wr     (buf_wr)
    );

    line_buffer u_line_buffer (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .buf_wr     (buf_wr),
        .line_start (line_start),
        .line       (line),
        .pixel_req  (pixel_req),
        .pixel_x    (pixel_x),
        .rd_pixel   (rd_pixel),
        .rd_valid   (rd_valid)
    );

    colour_output u_colour (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .tbl_wr    (tbl_wr),
        .rd_pixel  (rd_pixel),
        .rd_valid  (rd_valid),
        .rgb       (rgb),
        .rgb_valid (rgb_valid)
    );

endmodule

// File: design/colour_output.sv
`timescale 1ns/1ps

module colour_output (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  sprite_pkg::table_write_t tbl_wr,
    input  sprite_pkg::pixel_t       rd_pixel,
    input  logic                     rd_valid,
    output sprite_pkg::rgb_t         rgb,
    output logic                     rgb_valid
);
    import sprite_pkg::*;

    logic [7:0]  clut    [2**clut_addr_bits];
    logic [31:0] palette [256];

    logic [7:0]  clut_q;
    logic [31:0] pal_q;

    // line buffer read already used one cycle of the latency
    logic [pix_latency-2:0] vld_sr;

    always_ff @(posedge clk_sys) begin
        if (tbl_wr.en && tbl_wr.sel == sel_clut) begin
            clut[tbl_wr.addr[clut_addr_bits-1:0]] <= tbl_wr.data[7:0];
        end
        if (tbl_wr.en && tbl_wr.sel == sel_palette) begin
            palette[tbl_wr.addr[7:0]] <= tbl_wr.data;
        end
    end

    // ==============================
    // pen to rgb pipeline
    // ==============================
    always_ff @(posedge clk_sys) begin
        // low six colour bits select the clut row
        clut_q <= clut[{rd_pixel.colour[5:0], rd_pixel.pen}];
        pal_q  <= palette[clut_q];
        // 4 bit guns, nibble repeated to fill 8 bits
        rgb.r  <= {2{pal_q[27:24]}};
        rgb.g  <= {2{pal_q[19:16]}};
        rgb.b  <= {2{pal_q[11:8]}};
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[pix_latency-3:0], rd_valid};
        end
    end

    assign rgb_valid = vld_sr[pix_latency-2];

endmodule

// File: design/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
    input  logic                    clk_sys,
    input  logic                    reset,
    input  sprite_pkg::line_write_t buf_wr,
    input  logic                    line_start,
    input  logic [7:0]              line,
    input  logic                    pixel_req,
    input  logic [7:0]              pixel_x,
    output sprite_pkg::pixel_t      rd_pixel,
    output logic                    rd_valid
);
    import sprite_pkg::*;

    pixel_t mem [2 * line_width];

    logic rd_bank;

    always_ff @(posedge clk_sys) begin
        if (buf_wr.en) begin
            mem[{buf_wr.bank, buf_wr.x}] <= buf_wr.pix;
        end
        if (pixel_req) begin
            rd_pixel <= mem[{rd_bank, pixel_x}];
        end
    end

    // display side reads the bank not being drawn
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rd_bank  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            if (line_start) begin
                rd_bank <= ~line[0];
            end
            rd_valid <= pixel_req;
        end
    end

endmodule

// File: design/column_renderer.sv
`timescale 1ns/1ps

module column_renderer (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  sprite_pkg::table_write_t tbl_wr,
    input  logic                     line_start,
    input  logic [7:0]               line,
    output logic                     line_busy,
    output logic                     line_done,
    output sprite_pkg::line_write_t  buf_wr
);
    import sprite_pkg::*;

    logic [15:0] spr_ram     [2**spr_ram_addr_bits];
    logic [15:0] bitmap      [2**bitmap_addr_bits];
    logic [7:0]  tile_colour [2**(tile_bits + 1)];

    render_state_e state;

    logic [7:0]           line_q;
    logic [7:0]           clear_x;
    logic [1:0]           pass;
    logic [1:0]           group;
    logic [4:0]           col;
    logic [7:0]           col_x;
    logic [7:0]           row_idx;
    logic [tile_bits-1:0] tile;
    logic                 flip_y;
    logic                 half;
    logic [1:0]           ofs;
    logic [3:0]           pen;

    logic [spr_ram_addr_bits-1:0] spr_rd_addr;
    logic [bitmap_addr_bits-1:0]  bmp_rd_addr;
    logic [tile_bits:0]           tc_rd_addr;
    logic [15:0]                  spr_q;
    logic [15:0]                  bmp_q;
    logic [7:0]                   tc_q;

    logic        wr_en_q;
    logic        wr_bank_q;
    logic [7:0]  wr_x_q;
    pixel_t      wr_pix_q;

    // groups are drawn 2, 3, 1 so group 1 wins overlaps
    always_comb begin
        case (pass)
            2'd0:    group = 2'd2;
            2'd1:    group = 2'd3;
            default: group = 2'd1;
        endcase
    end

    // ==============================
    // table addressing
    // ==============================
    always_comb begin
        if (state == st_tile_rd) begin
            spr_rd_addr = {group, col, row_idx[7:3]};
        end else begin
            spr_rd_addr = {2'b00, col, 3'b000, group};
        end
        tc_rd_addr  = {spr_q[tile_bits-1:0], spr_q[15]};
        bmp_rd_addr = {tile, half, flip_y ? ~row_idx[2:0] : row_idx[2:0]};
    end

    // bit planes interleaved within the word
    assign pen = {bmp_q[{2'b01, ofs}], bmp_q[{2'b00, ofs}],
                  bmp_q[{2'b11, ofs}], bmp_q[{2'b10, ofs}]};

    always_ff @(posedge clk_sys) begin
        if (tbl_wr.en && tbl_wr.sel == sel_spr_ram) begin
            spr_ram[tbl_wr.addr[spr_ram_addr_bits-1:0]] <= tbl_wr.data[15:0];
        end
        if (state == st_col_rd || state == st_tile_rd) begin
            spr_q <= spr_ram[spr_rd_addr];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (tbl_wr.en && tbl_wr.sel == sel_bitmap) begin
            bitmap[tbl_wr.addr[bitmap_addr_bits-1:0]] <= tbl_wr.data[15:0];
        end
        if (state == st_bmp_rd) begin
            bmp_q <= bitmap[bmp_rd_addr];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (tbl_wr.en && tbl_wr.sel == sel_tile_colour) begin
            tile_colour[tbl_wr.addr[tile_bits:0]] <= tbl_wr.data[7:0];
        end
        if (state == st_tile_data) begin
            tc_q <= tile_colour[tc_rd_addr];
        end
    end

    // ==============================
    // clear and draw sequencer
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (line_start) begin
                        line_q  <= line;
                        clear_x <= 8'd0;
                        state   <= st_clear;
                    end
                end
                st_clear: begin
                    clear_x <= clear_x + 8'd1;
                    if (clear_x == 8'(line_width - 1)) begin
                        pass  <= 2'd0;
                        col   <= 5'd0;
                        state <= st_col_rd;
                    end
                end
                st_col_rd: begin
                    state <= st_col_data;
                end
                st_col_data: begin
                    // row offset from the column top, col_y = 1 - y byte
                    col_x   <= spr_q[7:0];
                    row_idx <= line_q - (8'h01 - spr_q[15:8]);
                    state   <= st_tile_rd;
                end
                st_tile_rd: begin
                    state <= st_tile_data;
                end
                st_tile_data: begin
                    tile   <= spr_q[tile_bits-1:0];
                    flip_y <= spr_q[14];
                    half   <= 1'b0;
                    state  <= st_bmp_rd;
                end
                st_bmp_rd: begin
                    ofs   <= 2'd0;
                    state <= st_draw;
                end
                st_draw: begin
                    ofs <= ofs + 2'd1;
                    if (ofs == 2'd3) begin
                        if (!half) begin
                            // right half of the tile
                            half  <= 1'b1;
                            state <= st_bmp_rd;
                        end else begin
                            state <= st_next;
                        end
                    end
                end
                st_next: begin
                    if (col == 5'(num_columns - 1)) begin
                        col <= 5'd0;
                        if (pass == 2'(num_groups - 1)) begin
                            state <= st_done;
                        end else begin
                            pass  <= pass + 2'd1;
                            state <= st_col_rd;
                        end
                    end else begin
                        col   <= col + 5'd1;
                        state <= st_col_rd;
                    end
                end
                st_done: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // line buffer write port
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= (state == st_clear) || (state == st_draw && pen != 4'd0);
        end
    end

    always_ff @(posedge clk_sys) begin
        wr_bank_q <= line_q[0];
        if (state == st_clear) begin
            wr_x_q   <= clear_x;
            wr_pix_q <= '0;
        end else begin
            wr_x_q          <= col_x + {5'd0, half, ofs};
            wr_pix_q.colour <= tc_q;
            wr_pix_q.pen    <= pen;
        end
    end

    always_comb begin
        buf_wr.en   = wr_en_q;
        buf_wr.bank = wr_bank_q;
        buf_wr.x    = wr_x_q;
        buf_wr.pix  = wr_pix_q;
    end

    assign line_busy = (state != st_idle);
    assign line_done = (state == st_done);

endmodule

// File: design/table_loader.sv
`timescale 1ns/1ps

module table_loader (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  sprite_pkg::dl_byte_t     dl,
    output sprite_pkg::table_write_t tbl_wr
);
    import sprite_pkg::*;

    logic        hit;
    logic        last;
    table_sel_e  sel;
    logic [19:0] offset;
    logic [13:0] word_addr;
    logic [31:0] word_data;

    // earlier bytes of the word being built, newest in the low byte
    logic [23:0] asm_q;

    logic        wr_en_q;
    table_sel_e  sel_q;
    logic [13:0] addr_q;
    logic [31:0] data_q;

    // ==============================
    // address decode
    // ==============================
    always_comb begin
        hit       = 1'b1;
        last      = 1'b0;
        sel       = sel_spr_ram;
        offset    = '0;
        word_addr = '0;
        word_data = '0;
        if (dl.addr < dl_spr_end) begin
            // 16 bit words, high byte first
            offset    = dl.addr - dl_spr_base;
            last      = offset[0];
            word_addr = 14'(offset[12:1]);
            word_data = {16'h0000, asm_q[7:0], dl.data};
        end else if (dl.addr < dl_bitmap_base) begin
            hit = 1'b0;
        end else if (dl.addr < dl_tile_colour_base) begin
            sel       = sel_bitmap;
            offset    = dl.addr - dl_bitmap_base;
            last      = offset[0];
            word_addr = offset[14:1];
            word_data = {16'h0000, asm_q[7:0], dl.data};
        end else if (dl.addr < dl_clut_base) begin
            // one byte per entry
            sel       = sel_tile_colour;
            offset    = dl.addr - dl_tile_colour_base;
            last      = 1'b1;
            word_addr = 14'(offset[10:0]);
            word_data = {24'h000000, dl.data};
        end else if (dl.addr < dl_palette_base) begin
            // two low nibbles, first byte in the low half
            sel       = sel_clut;
            offset    = dl.addr - dl_clut_base;
            last      = offset[0];
            word_addr = 14'(offset[10:1]);
            word_data = {24'h000000, dl.data[3:0], asm_q[3:0]};
        end else if (dl.addr < dl_end) begin
            sel       = sel_palette;
            offset    = dl.addr - dl_palette_base;
            last      = (offset[1:0] == 2'b11);
            word_addr = 14'(offset[9:2]);
            word_data = {asm_q, dl.data};
        end else begin
            hit = 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (dl.wr && hit) begin
            asm_q <= {asm_q[15:0], dl.data};
        end
        if (dl.wr && hit && last) begin
            sel_q  <= sel;
            addr_q <= word_addr;
            data_q <= word_data;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= dl.wr && hit && last;
        end
    end

    always_comb begin
        tbl_wr.en   = wr_en_q;
        tbl_wr.sel  = sel_q;
        tbl_wr.addr = addr_q;
        tbl_wr.data = data_q;
    end

endmodule

// File: design/sprite_pkg.sv
package sprite_pkg;

    // ==============================
    // geometry and table sizes
    // ==============================
    localparam int num_columns       = 32;
    localparam int num_groups        = 3;
    localparam int line_width        = 256;
    localparam int tile_bits         = 10;
    localparam int spr_ram_addr_bits = 12;
    localparam int bitmap_addr_bits  = 14;
    localparam int clut_addr_bits    = 10;

    // download byte map
    localparam logic [19:0] dl_spr_base         = 20'h00000;
    localparam logic [19:0] dl_spr_end          = 20'h02000;
    localparam logic [19:0] dl_bitmap_base      = 20'h08000;
    localparam logic [19:0] dl_tile_colour_base = 20'h10000;
    localparam logic [19:0] dl_clut_base        = 20'h10800;
    localparam logic [19:0] dl_palette_base     = 20'h11000;
    localparam logic [19:0] dl_end              = 20'h11400;

    // pixel_req to rgb_valid
    localparam int pix_latency = 4;

    typedef enum logic [2:0] {
        sel_spr_ram,
        sel_bitmap,
        sel_tile_colour,
        sel_clut,
        sel_palette
    } table_sel_e;

    typedef enum logic [3:0] {
        st_idle,
        st_clear,
        st_col_rd,
        st_col_data,
        st_tile_rd,
        st_tile_data,
        st_bmp_rd,
        st_draw,
        st_next,
        st_done
    } render_state_e;

    typedef struct packed {
        logic        wr;
        logic [19:0] addr;
        logic [7:0]  data;
    } dl_byte_t;

    typedef struct packed {
        logic        en;
        table_sel_e  sel;
        logic [13:0] addr;
        logic [31:0] data;
    } table_write_t;

    typedef struct packed {
        logic [7:0] colour;
        logic [3:0] pen;
    } pixel_t;

    typedef struct packed {
        logic       en;
        logic       bank;
        logic [7:0] x;
        pixel_t     pix;
    } line_write_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage
